/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f tb.f --top-module elbeth_id_tb -o elbeth_id_sim \
	&& ./obj_dir/elbeth_id_sim \
	|| { echo "simulation failed"; exit 1; }

/* tb.f */
verilog/elbeth_isa_pkg.sv
verilog/elbeth_pipe_pkg.sv
verilog/elbeth_decoder.sv
verilog/elbeth_imm_gen.sv
verilog/elbeth_id_stage.sv
verilog/elbeth_id_top.sv
tb/elbeth_id_checker.sv
tb/elbeth_id_tb.sv

/* tb/elbeth_id_checker.sv */
// decode stage checker
// reference decode and concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module elbeth_id_checker
	import elbeth_isa_pkg::*, elbeth_pipe_pkg::*;
(
	input wire logic        clk,
	input wire logic        rst_n,
	input wire logic        if_valid,
	input wire logic [31:0] if_pc,
	input wire logic [31:0] if_inst,
	input wire logic [1:0]  csr_prv,
	input wire logic        stall,
	input wire logic        flush,
	input id_ex_t           id_ex
);

	// inputs of the previous edge
	logic        p_rstn  = 1'b0;
	logic        p_valid = 1'b0;
	logic        p_stall = 1'b0;
	logic        p_flush = 1'b0;
	logic [31:0] p_pc    = 32'd0;
	logic [31:0] p_inst  = 32'd0;
	logic [1:0]  p_prv   = 2'd0;
	id_ex_t      p_idex  = '0;

	// first failure, read by the testbench
	logic        fail_flag = 1'b0;
	string       fail_name;
	logic [63:0] fail_exp;
	logic [63:0] fail_got;
	time         fail_time;

	always @(posedge clk) begin
		p_rstn  <= rst_n;
		p_valid <= if_valid;
		p_stall <= stall;
		p_flush <= flush;
		p_pc    <= if_pc;
		p_inst  <= if_inst;
		p_prv   <= csr_prv;
		p_idex  <= id_ex;
	end

	task automatic flag_error(input string name, input logic [63:0] e, input logic [63:0] g);
		if (!fail_flag) begin
			fail_name = name;
			fail_exp  = e;
			fail_got  = g;
			fail_time = $time;
			fail_flag = 1'b1;
		end
	endtask

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	//////////////////////////////////////////////////
	// reference decode of the previous word
	//////////////////////////////////////////////////
	logic [6:0]  op;
	logic [2:0]  f3;
	logic [4:0]  rs1f;
	logic        is_r, is_i, is_ld, is_st, is_br, is_jal, is_jalr, is_lui, is_aui;
	logic        is_sys, is_mul, known, ld_ok, st_ok, br_ok, alu_cls, csr_form;
	logic        illegal_word, go, chk;
	logic [3:0]  exp_alu, exp_mem, exp_br;
	logic [4:0]  exp_rs1, exp_rs2;
	logic [31:0] exp_imm, exp_mimm, exp_off, exp_tgt;
	logic [2:0]  exp_cmd;

	assign op      = p_inst[6:0];
	assign f3      = p_inst[14:12];
	assign rs1f    = p_inst[19:15];
	assign is_r    = (op == OP_TYPE_R);
	assign is_i    = (op == OP_TYPE_I);
	assign is_ld   = (op == OP_LOAD);
	assign is_st   = (op == OP_STORE);
	assign is_br   = (op == OP_BRANCH);
	assign is_jal  = (op == OP_JAL);
	assign is_jalr = (op == OP_JALR);
	assign is_lui  = (op == OP_LUI);
	assign is_aui  = (op == OP_AUIPC);
	assign is_sys  = (op == OP_SYSTEM);
	assign is_mul  = (op == OP_MULT);
	assign known   = is_r | is_i | is_ld | is_st | is_br | is_jal | is_jalr | is_lui |
		is_aui | is_sys | is_mul | (op == OP_FENCE);
	assign ld_ok   = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
	assign st_ok   = (f3 <= 3'd2);
	assign br_ok   = (f3 != 3'd2) && (f3 != 3'd3);
	assign alu_cls = is_r | is_i | is_lui | is_aui;
	assign csr_form = is_sys && (f3 != 3'd0) && (f3 != 3'd4);
	assign illegal_word = !known || (is_ld && !ld_ok) || (is_st && !st_ok) || (is_br && !br_ok);

	always_comb begin
		// alu code is {alt, funct3}, alt only for shifts and register sub
		exp_alu = 4'd0;
		if (is_r || is_i)
			exp_alu = {((f3 == 3'd5) || (is_r && f3 == 3'd0)) ? p_inst[30] : 1'b0, f3};
		exp_rs1 = (is_r || is_i) ? rs1f : 5'd0;
		exp_rs2 = is_r ? p_inst[24:20] : 5'd0;
		exp_imm = 32'd0;
		if (is_i)
			exp_imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, p_inst[24:20]} : sext12(p_inst[31:20]);
		else if (is_lui || is_aui)
			exp_imm = {p_inst[31:12], 12'd0};
		exp_mem  = (f3 <= 3'd2) ? {1'b0, f3} + 4'd1 : {1'b0, f3};
		exp_mimm = is_ld ? sext12(p_inst[31:20]) : sext12({p_inst[31:25], p_inst[11:7]});
		exp_br   = is_jal ? 4'd7 : is_jalr ? 4'd8 :
			(f3 < 3'd2) ? {1'b0, f3} + 4'd1 : {1'b0, f3} - 4'd1;
		if (is_br)
			exp_off = {{20{p_inst[31]}}, p_inst[7], p_inst[30:25], p_inst[11:8], 1'b0};
		else if (is_jal)
			exp_off = {{12{p_inst[31]}}, p_inst[19:12], p_inst[20], p_inst[30:21], 1'b0};
		else
			exp_off = sext12(p_inst[31:20]) & ~32'd1;
		exp_tgt = is_jalr ? exp_off : p_pc + exp_off;
		exp_cmd = (rs1f == 5'd0) ? 3'd1 : {1'b0, f3[1:0]} + 3'd1;
	end

	assign go  = p_rstn && !p_flush && !p_stall;
	assign chk = go && p_valid;

	//////////////////////////////////////////////////
	// assertions
	//////////////////////////////////////////////////
	a_reset: assert property (@(posedge clk) !p_rstn |-> !id_ex.valid && !id_ex.ctrl.except)
		else begin
			flag_error("reset valid/except", 64'd0, {62'd0, id_ex.valid, id_ex.ctrl.except});
			$error("bubble expected in reset");
		end
	a_flush: assert property (@(posedge clk) p_rstn && p_flush |-> !id_ex.valid)
		else begin
			flag_error("flush valid", 64'd0, {63'd0, id_ex.valid});
			$error("flush left valid set");
		end
	a_hold: assert property (@(posedge clk) p_rstn && !p_flush && p_stall |-> id_ex == p_idex)
		else begin
			flag_error("stall hold id_ex", p_idex[63:0], id_ex[63:0]);
			$error("stall did not hold");
		end
	a_pass: assert property (@(posedge clk) go |-> {id_ex.valid, id_ex.pc} == {p_valid, p_pc})
		else begin
			flag_error("valid/pc", {31'd0, p_valid, p_pc}, {31'd0, id_ex.valid, id_ex.pc});
			$error("valid or pc wrong");
		end
	// invalid slots carry a random word, so a trap would leak here
	a_bubble: assert property (@(posedge clk) go && !p_valid |->
		!id_ex.ctrl.except && !id_ex.ctrl.eret)
		else begin
			flag_error("bubble except/eret", 64'd0,
				{62'd0, id_ex.ctrl.except, id_ex.ctrl.eret});
			$error("bubble reported a trap");
		end
	a_alu: assert property (@(posedge clk) chk && alu_cls |->
		{id_ex.ctrl.alu_op, id_ex.ctrl.rd, id_ex.ctrl.rs1, id_ex.ctrl.rs2,
		id_ex.ctrl.uses_imm, id_ex.imm.imm} ==
		{exp_alu, p_inst[11:7], exp_rs1, exp_rs2, !is_r, exp_imm})
		else begin
			flag_error("alu_op/regs/uses_imm/imm",
				{12'd0, exp_alu, p_inst[11:7], exp_rs1, exp_rs2, !is_r, exp_imm},
				{12'd0, id_ex.ctrl.alu_op, id_ex.ctrl.rd, id_ex.ctrl.rs1, id_ex.ctrl.rs2,
				id_ex.ctrl.uses_imm, id_ex.imm.imm});
			$error("alu class decode wrong");
		end
	a_mem: assert property (@(posedge clk) chk && ((is_ld && ld_ok) || (is_st && st_ok)) |->
		{id_ex.ctrl.mem_op, id_ex.imm.imm} == {exp_mem, exp_mimm})
		else begin
			flag_error("mem_op/imm", {28'd0, exp_mem, exp_mimm},
				{28'd0, id_ex.ctrl.mem_op, id_ex.imm.imm});
			$error("memory decode wrong");
		end
	a_br: assert property (@(posedge clk) chk && ((is_br && br_ok) || is_jal || is_jalr) |->
		{id_ex.ctrl.br_op, id_ex.imm.br_offset, id_ex.target} == {exp_br, exp_off, exp_tgt})
		else begin
			flag_error("br_op/br_offset/target", {exp_off, exp_tgt},
				{id_ex.imm.br_offset, id_ex.target});
			$error("control flow decode wrong");
		end
	a_csr: assert property (@(posedge clk) chk && csr_form |->
		{id_ex.ctrl.csr_cmd, id_ex.ctrl.csr_addr, id_ex.ctrl.except} ==
		{exp_cmd, p_inst[31:20], 1'b0})
		else begin
			flag_error("csr_cmd/csr_addr", {49'd0, exp_cmd, p_inst[31:20]},
				{49'd0, id_ex.ctrl.csr_cmd, id_ex.ctrl.csr_addr});
			$error("csr decode wrong");
		end
	a_ecall: assert property (@(posedge clk) chk && p_inst == 32'h0000_0073 |->
		id_ex.ctrl.except && id_ex.ctrl.except_src == 4'd8 + {2'd0, p_prv})
		else begin
			flag_error("ecall except_src", {60'd0, 4'd8 + {2'd0, p_prv}},
				{60'd0, id_ex.ctrl.except_src});
			$error("ecall not trapped");
		end
	a_eret: assert property (@(posedge clk) chk && p_inst == 32'h1000_0073 |->
		(p_prv == 2'd0) ? (id_ex.ctrl.except && id_ex.ctrl.except_src == 4'd2) :
		(id_ex.ctrl.eret && !id_ex.ctrl.except))
		else begin
			flag_error("eret/except", {62'd0, p_prv != 2'd0, p_prv == 2'd0},
				{62'd0, id_ex.ctrl.eret, id_ex.ctrl.except});
			$error("eret decode wrong");
		end
	a_illegal: assert property (@(posedge clk) chk && illegal_word |->
		id_ex.ctrl.except && id_ex.ctrl.except_src == 4'd2)
		else begin
			flag_error("illegal except_src", 64'd2, {60'd0, id_ex.ctrl.except_src});
			$error("illegal word not trapped");
		end
	a_mult: assert property (@(posedge clk) chk && is_mul |->
		{id_ex.ctrl.mult_sel, id_ex.ctrl.except} == {f3 != 3'd0, 1'b0})
		else begin
			flag_error("mult_sel/except", {62'd0, f3 != 3'd0, 1'b0},
				{62'd0, id_ex.ctrl.mult_sel, id_ex.ctrl.except});
			$error("mult decode wrong");
		end

endmodule

bind elbeth_id_top elbeth_id_checker u_chk (.*);

`default_nettype wire

/* tb/elbeth_id_tb.sv */
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module elbeth_id_tb
	import elbeth_pipe_pkg::*;
();

	localparam int NUM_INST   = 2000;
	localparam int MAX_CYCLES = 2500;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        if_valid;
	logic [31:0] if_pc;
	logic [31:0] if_inst;
	logic [1:0]  csr_prv;
	logic        stall;
	logic        flush;
	id_ex_t      id_ex;
	int          cycles = 0;
	int          issued;

	elbeth_id_top #(.ENABLE_MULT(1'b1)) dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_valid (if_valid),
		.if_pc    (if_pc),
		.if_inst  (if_inst),
		.csr_prv  (csr_prv),
		.stall    (stall),
		.flush    (flush),
		.id_ex    (id_ex)
	);

	always #4 clk = ~clk; // 8 ns period

	// random word from one of the instruction classes
	function automatic logic [31:0] make_inst();
		logic [31:0] w;
		logic [2:0]  f3;
		w = $urandom;
		case ($urandom_range(0, 12))
			0:  w[6:0] = 7'b0110011;
			1:  w[6:0] = 7'b0010011;
			2:  w[6:0] = 7'b0000011;
			3:  w[6:0] = 7'b0100011;
			4:  w[6:0] = 7'b1100011;
			5:  w[6:0] = 7'b1101111;
			6:  w[6:0] = 7'b1100111;
			7:  w[6:0] = 7'b0110111;
			8:  w[6:0] = 7'b0010111;
			9: begin
				w[6:0] = 7'b1110011;
				f3 = 3'($urandom_range(1, 6));
				w[14:12] = (f3 >= 3'd4) ? f3 + 3'd1 : f3; // skip 4
				if ($urandom_range(0, 1) == 0)
					w[19:15] = 5'd0; // read-only form
			end
			10: begin
				case ($urandom_range(0, 2))
					0:       w = 32'h0000_0073; // ecall
					1:       w = 32'h1000_0073; // eret
					default: w = 32'h0010_0073; // ebreak
				endcase
			end
			11: w[6:0] = 7'b0001011;
			default: ; // fully random
		endcase
		return w;
	endfunction

	task automatic drive_cycle();
		stall    = ($urandom_range(0, 15) == 0);
		flush    = ($urandom_range(0, 31) == 0);
		if_valid = ($urandom_range(0, 7) != 0);
		if_pc    = $urandom & 32'hffff_fffc;
		if_inst  = make_inst();
		csr_prv  = 2'($urandom);
	endtask

	//////////////////////////////////////////////////
	// failure watch and timeout
	//////////////////////////////////////////////////
	always @(posedge dut.u_chk.fail_flag) begin
		$display("MISMATCH at %0t: %s expected %0h got %0h", dut.u_chk.fail_time,
			dut.u_chk.fail_name, dut.u_chk.fail_exp, dut.u_chk.fail_got);
		$display("=== FAIL ===");
		$fatal(1, "checker assertion failed");
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles", cycles);
			$display("=== FAIL ===");
			$fatal(1, "run did not finish in time");
		end
	end

	initial begin
		void'($urandom(32'hf063));
		rst_n    = 1'b0;
		if_valid = 1'b0;
		if_pc    = 32'd0;
		if_inst  = 32'd0;
		csr_prv  = 2'd0;
		stall    = 1'b0;
		flush    = 1'b0;
		issued   = 0;

		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk); // first cycle after reset stays a bubble

		while (issued < NUM_INST) begin
			#1 drive_cycle();
			if (!stall)
				issued = issued + 1;
			@(posedge clk);
		end
		#1 if_valid = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		repeat (2) @(posedge clk);
		#1;

		if (dut.u_chk.fail_flag) begin
			$display("=== FAIL ===");
			$fatal(1, "checker reported a failure");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/elbeth_decoder.sv */
// instruction decoder
// control fields and exception detection
`timescale 1ns/1ps
`default_nettype none

module elbeth_decoder
	import elbeth_isa_pkg::*, elbeth_pipe_pkg::*;
#(
	parameter bit ENABLE_MULT = 1'b1
) (
	input  wire logic [31:0] inst,
	input  wire logic [1:0]  csr_prv,
	output id_ctrl_t         ctrl
);

	logic [4:0]  rd_fld;
	logic [4:0]  rs1_fld;
	logic [4:0]  rs2_fld;
	logic [2:0]  funct3;
	logic        funct7_b5;
	logic [11:0] funct12;
	logic        rs1_zero;
	logic        illegal;
	logic        ecall;

	assign rd_fld    = inst[11:7];
	assign funct3    = inst[14:12];
	assign rs1_fld   = inst[19:15];
	assign rs2_fld   = inst[24:20];
	assign funct7_b5 = inst[30];
	assign funct12   = inst[31:20];
	assign rs1_zero  = (rs1_fld == 5'd0); // field itself, not the decoded rs1

	// shared alu table, sub only exists in the register form
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
		input logic is_reg);
		case (f3)
			3'd0:    alu_sel = (alt && is_reg) ? ALU_SUB : ALU_ADD;
			3'd1:    alu_sel = ALU_SLL;
			3'd2:    alu_sel = ALU_SLT;
			3'd3:    alu_sel = ALU_SLTU;
			3'd4:    alu_sel = ALU_XOR;
			3'd5:    alu_sel = alt ? ALU_SRA : ALU_SRL;
			3'd6:    alu_sel = ALU_OR;
			default: alu_sel = ALU_AND;
		endcase
	endfunction

	always_comb begin
		// defaults everywhere, no latches
		ctrl            = '0;
		ctrl.alu_op     = ALU_ADD;
		ctrl.br_op      = BR_NONE;
		ctrl.mem_op     = MEM_NONE;
		ctrl.csr_cmd    = CSR_NONE;
		ctrl.except_src = ECODE_NONE;
		illegal         = 1'b0;
		ecall           = 1'b0;

		case (inst[6:0])
			OP_MULT: begin
				if (ENABLE_MULT) begin
					ctrl.rd       = rd_fld;
					ctrl.rs1      = rs1_fld;
					ctrl.rs2      = rs2_fld;
					ctrl.mult_sel = (funct3 != 3'd0);
				end else begin
					illegal = 1'b1;
				end
			end
			OP_TYPE_R: begin
				ctrl.rd     = rd_fld;
				ctrl.rs1    = rs1_fld;
				ctrl.rs2    = rs2_fld;
				ctrl.alu_op = alu_sel(funct3, funct7_b5, 1'b1);
			end
			OP_TYPE_I: begin
				ctrl.rd       = rd_fld;
				ctrl.rs1      = rs1_fld;
				ctrl.uses_imm = 1'b1;
				ctrl.alu_op   = alu_sel(funct3, funct7_b5, 1'b0);
			end
			OP_LOAD: begin
				ctrl.rd       = rd_fld;
				ctrl.rs1      = rs1_fld;
				ctrl.uses_imm = 1'b1;
				case (funct3)
					3'd0:    ctrl.mem_op = MEM_BYTE;
					3'd1:    ctrl.mem_op = MEM_HALFWORD;
					3'd2:    ctrl.mem_op = MEM_WORD;
					3'd4:    ctrl.mem_op = MEM_BYTE_UNSIGNED;
					3'd5:    ctrl.mem_op = MEM_HALFWORD_UNSIGNED;
					default: illegal = 1'b1;
				endcase
			end
			OP_STORE: begin
				ctrl.rs1      = rs1_fld;
				ctrl.rs2      = rs2_fld;
				ctrl.uses_imm = 1'b1;
				ctrl.is_store = 1'b1;
				case (funct3)
					3'd0:    ctrl.mem_op = MEM_BYTE;
					3'd1:    ctrl.mem_op = MEM_HALFWORD;
					3'd2:    ctrl.mem_op = MEM_WORD;
					default: illegal = 1'b1;
				endcase
			end
			OP_BRANCH: begin
				ctrl.rs1 = rs1_fld;
				ctrl.rs2 = rs2_fld;
				case (funct3)
					3'd0:    ctrl.br_op = BR_BEQ;
					3'd1:    ctrl.br_op = BR_BNE;
					3'd4:    ctrl.br_op = BR_BLT;
					3'd5:    ctrl.br_op = BR_BGE;
					3'd6:    ctrl.br_op = BR_BLTU;
					3'd7:    ctrl.br_op = BR_BGEU;
					default: illegal = 1'b1;
				endcase
			end
			OP_JAL, OP_JALR: begin
				// link value is pc + 4
				ctrl.rd       = rd_fld;
				ctrl.uses_pc  = 1'b1;
				ctrl.uses_imm = 1'b1;
				if (inst[6:0] == OP_JALR) begin
					ctrl.rs1   = rs1_fld;
					ctrl.br_op = BR_JALR;
				end else begin
					ctrl.br_op = BR_JAL;
				end
			end
			OP_LUI: begin
				ctrl.rd       = rd_fld;
				ctrl.uses_imm = 1'b1; // rs1 stays x0
			end
			OP_AUIPC: begin
				ctrl.rd       = rd_fld;
				ctrl.uses_pc  = 1'b1;
				ctrl.uses_imm = 1'b1;
			end
			OP_FENCE: ; // no-op here
			OP_SYSTEM: begin
				ctrl.csr_addr = funct12;
				case (funct3)
					F3_PRIV: begin
						if (rs1_zero && rd_fld == 5'd0) begin
							case (funct12)
								FUNCT12_ECALL:  ecall = 1'b1;
								FUNCT12_EBREAK: ; // no debug support
								FUNCT12_ERET: begin
									if (csr_prv == 2'd0)
										illegal = 1'b1;
									else
										ctrl.eret = 1'b1;
								end
								default: illegal = 1'b1;
							endcase
						end else begin
							illegal = 1'b1;
						end
					end
					F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: begin
						ctrl.rd       = rd_fld;
						ctrl.rs1      = funct3[2] ? 5'd0 : rs1_fld; // uimm lives in rs1 field
						ctrl.uses_imm = funct3[2];
						case (funct3[1:0])
							2'd1:    ctrl.csr_cmd = rs1_zero ? CSR_READ : CSR_WRITE;
							2'd2:    ctrl.csr_cmd = rs1_zero ? CSR_READ : CSR_SET;
							default: ctrl.csr_cmd = rs1_zero ? CSR_READ : CSR_CLEAR;
						endcase
					end
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase

		ctrl.except = illegal | ecall;
		if (illegal)
			ctrl.except_src = ECODE_ILLEGAL_INST;
		else if (ecall)
			ctrl.except_src = ECODE_ECALL_FROM_U + {2'b00, csr_prv};
	end

endmodule

`default_nettype wire

/* verilog/elbeth_id_stage.sv */
// decode/execute pipeline register
// target adder and exception masking
`timescale 1ns/1ps
`default_nettype none

module elbeth_id_stage
	import elbeth_isa_pkg::*, elbeth_pipe_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        valid,
	input  wire logic [31:0] pc,
	input  id_ctrl_t         ctrl,
	input  id_imm_t          imm,
	input  wire logic        stall,
	input  wire logic        flush,
	output id_ex_t           id_ex
);

	// all NONE codes and ALU_ADD are zero
	localparam id_ex_t ID_EX_BUBBLE = '0;

	id_ex_t      nxt;
	logic [31:0] target;

	//////////////////////////////////////////////////
	// branch / jump target
	//////////////////////////////////////////////////
	always_comb begin
		case (ctrl.br_op)
			BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL:
				target = pc + imm.br_offset;
			BR_JALR:
				target = imm.br_offset; // rs1 added in execute
			default:
				target = 32'd0;
		endcase
	end

	always_comb begin
		nxt             = '0;
		nxt.valid       = valid;
		nxt.pc          = pc;
		nxt.ctrl        = ctrl;
		nxt.ctrl.except = ctrl.except & valid; // bubbles never trap
		nxt.ctrl.eret   = ctrl.eret & valid;
		nxt.imm         = imm;
		nxt.target      = target;
	end

	//////////////////////////////////////////////////
	// stage register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex <= ID_EX_BUBBLE;
		end else if (flush) begin
			id_ex <= ID_EX_BUBBLE; // flush beats stall
		end else if (!stall) begin
			id_ex <= nxt;
		end
	end

endmodule

`default_nettype wire

/* verilog/elbeth_id_top.sv */
// decode stage top level
`timescale 1ns/1ps
`default_nettype none

module elbeth_id_top
	import elbeth_pipe_pkg::*;
#(
	parameter bit ENABLE_MULT = 1'b1
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        if_valid,
	input  wire logic [31:0] if_pc,
	input  wire logic [31:0] if_inst,
	input  wire logic [1:0]  csr_prv,
	input  wire logic        stall,
	input  wire logic        flush,
	output id_ex_t           id_ex
);

	id_ctrl_t ctrl;
	id_imm_t  imm;

	// both read the full word in parallel
	elbeth_decoder #(.ENABLE_MULT(ENABLE_MULT)) u_decoder (
		.inst    (if_inst),
		.csr_prv (csr_prv),
		.ctrl    (ctrl)
	);

	elbeth_imm_gen u_imm_gen (
		.inst (if_inst),
		.imm  (imm)
	);

	elbeth_id_stage u_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.valid (if_valid),
		.pc    (if_pc),
		.ctrl  (ctrl),
		.imm   (imm),
		.stall (stall),
		.flush (flush),
		.id_ex (id_ex)
	);

endmodule

`default_nettype wire

/* verilog/elbeth_imm_gen.sv */
// immediate and branch offset generator
`timescale 1ns/1ps
`default_nettype none

module elbeth_imm_gen
	import elbeth_isa_pkg::*, elbeth_pipe_pkg::*;
(
	input  wire logic [31:0] inst,
	output id_imm_t          imm
);

	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] u_imm;
	logic [31:0] b_off;
	logic [31:0] j_off;
	logic [31:0] shamt;
	logic [31:0] uimm;

	//////////////////////////////////////////////////
	// raw fields, one per format
	//////////////////////////////////////////////////
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign u_imm = {inst[31:12], 12'b0};
	assign b_off = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign j_off = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign shamt = {27'b0, inst[24:20]};
	assign uimm  = {27'b0, inst[19:15]};

	// pick by opcode
	always_comb begin
		imm = '0;
		case (inst[6:0])
			OP_TYPE_I: begin
				if (inst[13:12] == 2'b01) // slli, srli, srai
					imm.imm = shamt;
				else
					imm.imm = i_imm;
			end
			OP_LOAD:            imm.imm = i_imm;
			OP_STORE:           imm.imm = s_imm;
			OP_LUI, OP_AUIPC:   imm.imm = u_imm;
			OP_BRANCH:          imm.br_offset = b_off;
			OP_JAL: begin
				imm.imm       = 32'd4;
				imm.br_offset = j_off;
			end
			OP_JALR: begin
				imm.imm       = 32'd4;
				imm.br_offset = {i_imm[31:1], 1'b0}; // low bit cleared
			end
			OP_SYSTEM: begin
				if (inst[14:12] == F3_CSRRWI || inst[14:12] == F3_CSRRSI ||
					inst[14:12] == F3_CSRRCI)
					imm.imm = uimm;
			end
			default: ; // r, mult, fence: no immediate
		endcase
	end

endmodule

`default_nettype wire

/* verilog/elbeth_isa_pkg.sv */
// rv32i instruction set encodings
// control and exception codes
`default_nettype none

package elbeth_isa_pkg;

	//////////////////////////////////////////////////
	// major opcodes
	//////////////////////////////////////////////////
	typedef enum logic [6:0] {
		OP_TYPE_R  = 7'b0110011,
		OP_TYPE_I  = 7'b0010011,
		OP_LOAD    = 7'b0000011,
		OP_JALR    = 7'b1100111,
		OP_STORE   = 7'b0100011,
		OP_BRANCH  = 7'b1100011,
		OP_LUI     = 7'b0110111,
		OP_AUIPC   = 7'b0010111,
		OP_JAL     = 7'b1101111,
		OP_FENCE   = 7'b0001111,
		OP_SYSTEM  = 7'b1110011,
		OP_MULT    = 7'b0001011 // custom-0 slot
	} opcode_e;

	// system funct3
	localparam logic [2:0] F3_PRIV   = 3'd0;
	localparam logic [2:0] F3_CSRRW  = 3'd1;
	localparam logic [2:0] F3_CSRRS  = 3'd2;
	localparam logic [2:0] F3_CSRRC  = 3'd3;
	localparam logic [2:0] F3_CSRRWI = 3'd5;
	localparam logic [2:0] F3_CSRRSI = 3'd6;
	localparam logic [2:0] F3_CSRRCI = 3'd7;

	// priv funct12
	localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
	localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
	localparam logic [11:0] FUNCT12_ERET   = 12'h100;

	//////////////////////////////////////////////////
	// execute-side command codes
	//////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SLL  = 4'd1,
		ALU_SLT  = 4'd2,
		ALU_SLTU = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SRL  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_AND  = 4'd7,
		ALU_SUB  = 4'd8,
		ALU_SRA  = 4'd13
	} alu_op_e;

	// nine kinds, so one bit wider than a funct3
	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_BEQ  = 4'd1,
		BR_BNE  = 4'd2,
		BR_BLT  = 4'd3,
		BR_BGE  = 4'd4,
		BR_BLTU = 4'd5,
		BR_BGEU = 4'd6,
		BR_JAL  = 4'd7,
		BR_JALR = 4'd8
	} br_op_e;

	typedef enum logic [3:0] {
		MEM_NONE              = 4'd0,
		MEM_BYTE              = 4'd1,
		MEM_HALFWORD          = 4'd2,
		MEM_WORD              = 4'd3,
		MEM_BYTE_UNSIGNED     = 4'd4,
		MEM_HALFWORD_UNSIGNED = 4'd5
	} mem_op_e;

	typedef enum logic [2:0] {
		CSR_NONE  = 3'd0,
		CSR_READ  = 3'd1,
		CSR_WRITE = 3'd2,
		CSR_SET   = 3'd3,
		CSR_CLEAR = 3'd4
	} csr_cmd_e;

	// exception causes
	localparam logic [3:0] ECODE_NONE         = 4'd0;
	localparam logic [3:0] ECODE_ILLEGAL_INST = 4'd2;
	localparam logic [3:0] ECODE_ECALL_FROM_U = 4'd8; // + privilege level

endpackage

`default_nettype wire

/* verilog/elbeth_pipe_pkg.sv */
// decode stage pipeline structures
`default_nettype none

package elbeth_pipe_pkg;

	import elbeth_isa_pkg::*;

	// decoder result
	typedef struct packed {
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		alu_op_e     alu_op;
		br_op_e      br_op;
		mem_op_e     mem_op;
		logic        is_store;
		logic        uses_imm;  // operand b from imm
		logic        uses_pc;   // operand a from pc
		logic        mult_sel;
		csr_cmd_e    csr_cmd;
		logic [11:0] csr_addr;
		logic        eret;
		logic        except;
		logic [3:0]  except_src;
	} id_ctrl_t;

	// immediate generator result
	typedef struct packed {
		logic [31:0] imm;       // imm, shamt, uimm or link offset
		logic [31:0] br_offset;
	} id_imm_t;

	//////////////////////////////////////////////////
	// decode/execute register
	//////////////////////////////////////////////////
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		id_ctrl_t    ctrl;
		id_imm_t     imm;
		logic [31:0] target;    // jalr: offset only, execute adds rs1
	} id_ex_t;

endpackage

`default_nettype wire
